//--- filelist.f
hw/core_cfg_pkg.sv
hw/rv_isa_pkg.sv
hw/key_match_mux.sv
hw/inst_fetch.sv
hw/inst_queue.sv
hw/inst_decode.sv
hw/decode_frontend.sv
sim/tb_clock.sv
sim/decode_checker.sv
sim/decode_tb.sv

//--- hw/core_cfg_pkg.sv
// core configuration
package core_cfg_pkg;

  localparam int xlen = 64;  // integer data width
  localparam int ilen = 32;  // instruction width

  // one fetched instruction with its address, 96 bits
  typedef struct packed {
    logic [xlen-1:0] pc;
    logic [ilen-1:0] inst;
  } fetch_slot_t;

endpackage

//--- hw/decode_frontend.sv
// fetch and decode front end
`timescale 1ns/10ps

module decode_frontend import core_cfg_pkg::*, rv_isa_pkg::*; #(
  parameter int              queue_depth = 8,
  parameter logic [xlen-1:0] reset_pc    = '0
) (
  input  logic            clk,
  input  logic            reset,
  input  logic            run,
  input  logic            hold,
  output logic [xlen-1:0] imem_addr,
  output logic            imem_rd,
  input  logic [ilen-1:0] imem_data,
  output logic [xlen-1:0] pc,
  output logic [ilen-1:0] inst,
  output logic [xlen-1:0] imm_i,
  output logic [xlen-1:0] imm_u,
  output logic [xlen-1:0] imm_j,
  output logic [xlen-1:0] imm_b,
  output logic [xlen-1:0] imm_s,
  output logic [5:0]      shamt,
  output logic [4:0]      rd,
  output logic [4:0]      rs1,
  output logic [4:0]      rs2,
  output dec_op_t         op,
  output logic            dec_valid
);

  logic        push;
  logic        pop;
  logic        empty;
  logic        room;
  fetch_slot_t push_slot;
  fetch_slot_t head_slot;

  inst_fetch #(.reset_pc(reset_pc)) u_fetch (
    .clk       (clk),
    .reset     (reset),
    .run       (run),
    .room      (room),
    .imem_addr (imem_addr),
    .imem_rd   (imem_rd),
    .imem_data (imem_data),
    .push      (push),
    .push_slot (push_slot)
  );

  inst_queue #(.payload_t(fetch_slot_t), .queue_depth(queue_depth)) u_queue (
    .clk       (clk),
    .reset     (reset),
    .push      (push),
    .push_slot (push_slot),
    .pop       (pop),
    .head_slot (head_slot),
    .empty     (empty),
    .room      (room)
  );

  inst_decode u_decode (
    .clk       (clk),
    .reset     (reset),
    .hold      (hold),
    .empty     (empty),
    .head_slot (head_slot),
    .pop       (pop),
    .dec_valid (dec_valid),
    .pc        (pc),
    .inst      (inst),
    .imm_i     (imm_i),
    .imm_u     (imm_u),
    .imm_j     (imm_j),
    .imm_b     (imm_b),
    .imm_s     (imm_s),
    .shamt     (shamt),
    .rd        (rd),
    .rs1       (rs1),
    .rs2       (rs2),
    .op        (op)
  );

endmodule

//--- hw/inst_decode.sv
// instruction decoder
`timescale 1ns/10ps

module inst_decode import core_cfg_pkg::*, rv_isa_pkg::*; (
  input  logic            clk,
  input  logic            reset,
  input  logic            hold,
  input  logic            empty,
  input  fetch_slot_t     head_slot,
  output logic            pop,
  output logic            dec_valid,
  output logic [xlen-1:0] pc,
  output logic [ilen-1:0] inst,
  output logic [xlen-1:0] imm_i,
  output logic [xlen-1:0] imm_u,
  output logic [xlen-1:0] imm_j,
  output logic [xlen-1:0] imm_b,
  output logic [xlen-1:0] imm_s,
  output logic [5:0]      shamt,
  output logic [4:0]      rd,
  output logic [4:0]      rs1,
  output logic [4:0]      rs2,
  output dec_op_t         op
);

  logic [ilen-1:0] w;
  logic [6:0]      grp_ib;
  logic [1:0]      grp_uj;
  logic [7:0]      grp_rr;
  logic [1:0]      grp_sh;

  assign w   = head_slot.inst;
  assign pop = !empty && !hold;

  key_match_mux #(.nr_key(17), .key_len(10), .data_len(7)) u_grp_ib (
    .key       ({w[14:12], w[6:0]}),
    .key_table ({
      {3'b000, opc_jalr},      op_jalr,
      {3'b000, opc_branch},    op_beq,
      {3'b001, opc_branch},    op_bne,
      {3'b101, opc_branch},    op_bge,
      {3'b111, opc_branch},    op_bgeu,
      {3'b010, opc_load},      op_lw,
      {3'b100, opc_load},      op_lbu,
      {3'b000, opc_store},     op_sb,
      {3'b001, opc_store},     op_sh,
      {3'b010, opc_store},     op_sw,
      {3'b000, opc_op_imm},    op_addi,
      {3'b011, opc_op_imm},    op_sltiu,
      {3'b100, opc_op_imm},    op_xori,
      {3'b111, opc_op_imm},    op_andi,
      {3'b011, opc_load},      op_ld,
      {3'b011, opc_store},     op_sd,
      {3'b000, opc_op_imm_32}, op_addiw
    }),
    .value     (grp_ib)
  );

  key_match_mux #(.nr_key(3), .key_len(7), .data_len(2)) u_grp_uj (
    .key       (w[6:0]),
    .key_table ({
      opc_lui,   op_lui,
      opc_auipc, op_auipc,
      opc_jal,   op_jal
    }),
    .value     (grp_uj)
  );

  key_match_mux #(.nr_key(10), .key_len(17), .data_len(8)) u_grp_rr (
    .key       ({w[31:25], w[14:12], w[6:0]}),
    .key_table ({
      {7'b0000000, 3'b000, opc_op},    op_add,
      {7'b0100000, 3'b000, opc_op},    op_sub,
      {7'b0000000, 3'b011, opc_op},    op_sltu,
      {7'b0000000, 3'b110, opc_op},    op_or,
      {7'b0000000, 3'b111, opc_op},    op_and,
      {7'b0000000, 3'b000, opc_op_32}, op_addw,
      {7'b0000000, 3'b001, opc_op_32}, op_sllw,
      {7'b0000001, 3'b000, opc_op_32}, op_mulw,
      {7'b0000001, 3'b100, opc_op_32}, op_divw,
      {7'b0000001, 3'b110, opc_op_32}, op_remw
    }),
    .value     (grp_rr)
  );

  // rv64 shifts use a 6-bit shamt so funct6 is the key
  key_match_mux #(.nr_key(3), .key_len(16), .data_len(2)) u_grp_sh (
    .key       ({w[31:26], w[14:12], w[6:0]}),
    .key_table ({
      {6'b000000, 3'b001, opc_op_imm}, op_slli,
      {6'b000000, 3'b101, opc_op_imm}, op_srli,
      {6'b010000, 3'b101, opc_op_imm}, op_srai
    }),
    .value     (grp_sh)
  );

  always_ff @(posedge clk) begin
    if (reset) begin
      dec_valid <= 1'b0;
    end else begin
      dec_valid <= pop;
    end
  end

  always_ff @(posedge clk) begin
    if (pop) begin
      pc    <= head_slot.pc;
      inst  <= w;
      rd    <= w[11:7];
      rs1   <= w[19:15];
      rs2   <= w[24:20];
      shamt <= w[25:20];
      imm_i <= {{(xlen-12){w[31]}}, w[31:20]};
      imm_u <= {{(xlen-32){w[31]}}, w[31:12], 12'b0};
      imm_j <= {{(xlen-21){w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
      imm_b <= {{(xlen-13){w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
      imm_s <= {{(xlen-12){w[31]}}, w[31:25], w[11:7]};
      op    <= '{rr: grp_rr, sh: grp_sh, uj: grp_uj,
                 ebreak: (w == ebreak_word), ib: grp_ib};
    end
  end

  // group keys are disjoint, so a decoded word lands in one group at most
  a_one_group: assert property (@(posedge clk) disable iff (reset)
    dec_valid |-> $onehot0({|op.rr, |op.sh, |op.uj, op.ebreak, |op.ib}))
    else $error("decoded op matches more than one group");

endmodule

//--- hw/inst_fetch.sv
// instruction fetch unit
`timescale 1ns/10ps

module inst_fetch import core_cfg_pkg::*; #(
  parameter logic [xlen-1:0] reset_pc = '0
) (
  input  logic            clk,
  input  logic            reset,
  input  logic            run,
  input  logic            room,
  output logic [xlen-1:0] imem_addr,
  output logic            imem_rd,
  input  logic [ilen-1:0] imem_data,
  output logic            push,
  output fetch_slot_t     push_slot
);

  logic [xlen-1:0] pc;
  logic [xlen-1:0] rd_pc;  // pc of the read in flight
  logic            armed;  // keeps the bus quiet for a cycle after reset

  assign imem_addr = pc;
  assign imem_rd   = armed & run & room;  // room covers this read and the one returning

  always_ff @(posedge clk) begin
    if (reset) begin
      pc    <= reset_pc;
      armed <= 1'b0;
      push  <= 1'b0;
    end else begin
      armed <= 1'b1;
      push  <= imem_rd;  // word arrives one cycle later
      if (imem_rd) begin
        pc <= pc + xlen'(4);  // no redirects, straight line only
      end
    end
  end

  always_ff @(posedge clk) begin
    if (imem_rd) begin
      rd_pc <= pc;
    end
  end

  // pair returning word with the address it was read from
  assign push_slot = '{pc: rd_pc, inst: imem_data};

endmodule

//--- hw/inst_queue.sv
// instruction queue
`timescale 1ns/10ps

module inst_queue #(
  parameter type payload_t   = logic,
  parameter int  queue_depth = 8
) (
  input  logic     clk,
  input  logic     reset,
  input  logic     push,
  input  payload_t push_slot,
  input  logic     pop,
  output payload_t head_slot,
  output logic     empty,
  output logic     room
);

  localparam int ptr_w = $clog2(queue_depth);
  localparam int cnt_w = $clog2(queue_depth + 1);

  payload_t         mem [queue_depth];
  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;
  logic [cnt_w-1:0] count;
  logic             full;

  // wraps at depth, so non power of two depths work too
  function automatic logic [ptr_w-1:0] ptr_inc(input logic [ptr_w-1:0] p);
    logic [ptr_w-1:0] nxt;
    nxt = (p == ptr_w'(queue_depth - 1)) ? '0 : p + 1'b1;
    return nxt;
  endfunction

  assign full      = (count == cnt_w'(queue_depth));
  assign empty     = (count == '0);
  assign room      = (count <= cnt_w'(queue_depth - 2));  // two free slots
  assign head_slot = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= push_slot;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
      count <= count + cnt_w'(push) - cnt_w'(pop);
    end
  end

  // fetch must have backed off on room before the queue filled
  a_no_overflow: assert property (@(posedge clk) disable iff (reset)
    !(push && full))
    else $error("push into full instruction queue");

  // decoder must only pop when the head is valid
  a_no_underflow: assert property (@(posedge clk) disable iff (reset)
    !(pop && empty))
    else $error("pop from empty instruction queue");

endmodule

//--- hw/key_match_mux.sv
// key to value lookup
`timescale 1ns/10ps

module key_match_mux #(
  parameter int nr_key   = 2,
  parameter int key_len  = 1,
  parameter int data_len = 1
) (
  input  logic [key_len-1:0]                   key,
  input  logic [nr_key*(key_len+data_len)-1:0] key_table,
  output logic [data_len-1:0]                  value
);

  localparam int pair_len = key_len + data_len;

  // pairs are packed {key, value}, first listed pair at the top bits
  always_comb begin
    value = '0;  // no match gives zero
    for (int i = 0; i < nr_key; i++) begin
      if (key_table[i*pair_len + data_len +: key_len] == key) begin
        value = key_table[i*pair_len +: data_len];
      end
    end
  end

endmodule

//--- hw/rv_isa_pkg.sv
// rv64 decode constants
package rv_isa_pkg;

  // major opcodes, inst[6:0]
  localparam logic [6:0] opc_load      = 7'b0000011;
  localparam logic [6:0] opc_store     = 7'b0100011;
  localparam logic [6:0] opc_branch    = 7'b1100011;
  localparam logic [6:0] opc_jalr      = 7'b1100111;
  localparam logic [6:0] opc_jal       = 7'b1101111;
  localparam logic [6:0] opc_op_imm    = 7'b0010011;
  localparam logic [6:0] opc_op_imm_32 = 7'b0011011;
  localparam logic [6:0] opc_op        = 7'b0110011;
  localparam logic [6:0] opc_op_32     = 7'b0111011;
  localparam logic [6:0] opc_lui       = 7'b0110111;
  localparam logic [6:0] opc_auipc     = 7'b0010111;

  localparam logic [31:0] ebreak_word = 32'h00100073;

  // grouped operation code, one index per group, zero when unmatched
  typedef struct packed {
    logic [7:0] rr;      // register-register ops
    logic [1:0] sh;      // immediate shifts
    logic [1:0] uj;      // lui, auipc, jal
    logic       ebreak;
    logic [6:0] ib;      // i, b, s and load/store class
  } dec_op_t;

  // ib group
  localparam logic [6:0] op_jalr  = 7'd4;
  localparam logic [6:0] op_beq   = 7'd5;
  localparam logic [6:0] op_bne   = 7'd6;
  localparam logic [6:0] op_bge   = 7'd8;
  localparam logic [6:0] op_bgeu  = 7'd10;
  localparam logic [6:0] op_lw    = 7'd13;
  localparam logic [6:0] op_lbu   = 7'd14;
  localparam logic [6:0] op_sb    = 7'd16;
  localparam logic [6:0] op_sh    = 7'd17;
  localparam logic [6:0] op_sw    = 7'd18;
  localparam logic [6:0] op_addi  = 7'd19;
  localparam logic [6:0] op_sltiu = 7'd21;
  localparam logic [6:0] op_xori  = 7'd22;
  localparam logic [6:0] op_andi  = 7'd24;
  localparam logic [6:0] op_ld    = 7'd42;
  localparam logic [6:0] op_sd    = 7'd43;
  localparam logic [6:0] op_addiw = 7'd47;

  // uj group
  localparam logic [1:0] op_lui   = 2'd1;
  localparam logic [1:0] op_auipc = 2'd2;
  localparam logic [1:0] op_jal   = 2'd3;

  // rr group
  localparam logic [7:0] op_add  = 8'h04;
  localparam logic [7:0] op_sub  = 8'h05;
  localparam logic [7:0] op_sltu = 8'h08;
  localparam logic [7:0] op_or   = 8'h12;
  localparam logic [7:0] op_and  = 8'h13;
  localparam logic [7:0] op_addw = 8'h17;
  localparam logic [7:0] op_sllw = 8'h19;
  localparam logic [7:0] op_mulw = 8'h25;
  localparam logic [7:0] op_divw = 8'h26;
  localparam logic [7:0] op_remw = 8'h28;

  // sh group
  localparam logic [1:0] op_slli = 2'h1;
  localparam logic [1:0] op_srli = 2'h2;
  localparam logic [1:0] op_srai = 2'h3;

endpackage

//--- sim/decode_checker.sv
// decoded result checker
`timescale 1ns/10ps

module decode_checker import core_cfg_pkg::*, rv_isa_pkg::*; #(
  parameter int              n_tests  = 1,
  parameter logic [xlen-1:0] reset_pc = '0
) (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       imem_rd,
  input  logic [xlen-1:0]            imem_addr,
  input  logic                       dec_valid,
  input  logic [xlen-1:0]            pc,
  input  logic [ilen-1:0]            inst,
  input  logic [xlen-1:0]            imm_i,
  input  logic [xlen-1:0]            imm_u,
  input  logic [xlen-1:0]            imm_j,
  input  logic [xlen-1:0]            imm_b,
  input  logic [xlen-1:0]            imm_s,
  input  logic [5:0]                 shamt,
  input  logic [4:0]                 rd,
  input  logic [4:0]                 rs1,
  input  logic [4:0]                 rs2,
  input  dec_op_t                    op,
  input  logic [n_tests-1:0][95:0]   tbl_name,
  input  logic [n_tests-1:0][31:0]   tbl_word,
  input  logic [n_tests-1:0][4:0]    tbl_rd,
  input  logic [n_tests-1:0][4:0]    tbl_rs1,
  input  logic [n_tests-1:0][4:0]    tbl_rs2,
  input  logic [n_tests-1:0][5:0]    tbl_shamt,
  input  logic [n_tests-1:0][19:0]   tbl_op,
  input  logic [n_tests-1:0][7:0]    tbl_fmt,
  input  logic [n_tests-1:0][63:0]   tbl_imm,
  output int                         seen,
  output int                         pass_count,
  output int                         fail_count,
  output int                         other_errors
);

  logic reset_q = 1'b1;        // reset seen at the previous sample
  logic first_rd_seen = 1'b0;

  initial begin
    seen         = 0;
    pass_count   = 0;
    fail_count   = 0;
    other_errors = 0;
  end

  task automatic compare_field(input string label, input string field,
                               input logic [63:0] exp, input logic [63:0] act,
                               inout logic bad);
    if (act !== exp) begin
      $display("error %s %s expected %h actual %h", label, field, exp, act);
      bad = 1'b1;
    end
  endtask

  task automatic check_result();
    logic [xlen-1:0] idx;
    logic            bad;
    string           label;
    idx = (pc - reset_pc) >> 2;
    bad = 1'b0;
    if (idx >= n_tests) begin
      return;  // filler nops past the table
    end
    if (idx != seen) begin
      $display("result out of order: test %0d expected next, got pc %h", seen, pc);
      other_errors++;
      return;
    end
    label = string'(tbl_name[idx]);
    compare_field(label, "inst", tbl_word[idx], inst, bad);
    compare_field(label, "rd", tbl_rd[idx], rd, bad);
    compare_field(label, "rs1", tbl_rs1[idx], rs1, bad);
    compare_field(label, "rs2", tbl_rs2[idx], rs2, bad);
    compare_field(label, "shamt", tbl_shamt[idx], shamt, bad);
    compare_field(label, "op", tbl_op[idx], op, bad);
    case (tbl_fmt[idx])  // only the format the word belongs to
      "I": compare_field(label, "imm_i", tbl_imm[idx], imm_i, bad);
      "S": compare_field(label, "imm_s", tbl_imm[idx], imm_s, bad);
      "B": compare_field(label, "imm_b", tbl_imm[idx], imm_b, bad);
      "U": compare_field(label, "imm_u", tbl_imm[idx], imm_u, bad);
      "J": compare_field(label, "imm_j", tbl_imm[idx], imm_j, bad);
      default: ;
    endcase
    if (bad) begin
      fail_count++;
      $display("fail %s", label);
    end else begin
      pass_count++;
      $display("pass %s", label);
    end
    seen++;
  endtask

  // mid-cycle sampling, all dut outputs settled
  always @(negedge clk) begin
    if (reset || reset_q) begin
      if (dec_valid !== 1'b0 || imem_rd !== 1'b0) begin
        $display("reset check failed: dec_valid or imem_rd active around reset");
        other_errors++;
      end
    end
    reset_q = reset;
    if (!reset && imem_rd === 1'b1 && !first_rd_seen) begin
      first_rd_seen = 1'b1;
      if (imem_addr !== reset_pc) begin
        $display("error first_fetch imem_addr expected %h actual %h", reset_pc, imem_addr);
        other_errors++;
      end
    end
    if (!reset && dec_valid === 1'b1) begin
      check_result();
    end
  end

endmodule

//--- sim/decode_tb.sv
// decode front end testbench
`timescale 1ns/10ps

module decode_tb import core_cfg_pkg::*, rv_isa_pkg::*; ();

  localparam int              n_tests  = 37;
  localparam logic [xlen-1:0] reset_pc = '0;
  localparam real             period   = 4.0;
  localparam real             limit_ns = (n_tests * 20 + 5) * period;

  logic            clk;
  logic            reset;
  logic            run;
  logic            hold;
  logic [xlen-1:0] imem_addr;
  logic            imem_rd;
  logic [ilen-1:0] imem_data;
  logic [xlen-1:0] pc;
  logic [ilen-1:0] inst;
  logic [xlen-1:0] imm_i;
  logic [xlen-1:0] imm_u;
  logic [xlen-1:0] imm_j;
  logic [xlen-1:0] imm_b;
  logic [xlen-1:0] imm_s;
  logic [5:0]      shamt;
  logic [4:0]      rd;
  logic [4:0]      rs1;
  logic [4:0]      rs2;
  dec_op_t         op;
  logic            dec_valid;

  // instruction table, one column per field
  logic [n_tests-1:0][95:0] tbl_name;
  logic [n_tests-1:0][31:0] tbl_word;
  logic [n_tests-1:0][4:0]  tbl_rd;
  logic [n_tests-1:0][4:0]  tbl_rs1;
  logic [n_tests-1:0][4:0]  tbl_rs2;
  logic [n_tests-1:0][5:0]  tbl_shamt;
  logic [n_tests-1:0][19:0] tbl_op;
  logic [n_tests-1:0][7:0]  tbl_fmt;
  logic [n_tests-1:0][63:0] tbl_imm;

  int seen;
  int pass_count;
  int fail_count;
  int other_errors;

  tb_clock #(.period(period)) u_clock (.clk(clk));

  decode_frontend #(.queue_depth(8), .reset_pc(reset_pc)) uut (
    .clk(clk), .reset(reset), .run(run), .hold(hold),
    .imem_addr(imem_addr), .imem_rd(imem_rd), .imem_data(imem_data),
    .pc(pc), .inst(inst), .imm_i(imm_i), .imm_u(imm_u), .imm_j(imm_j),
    .imm_b(imm_b), .imm_s(imm_s), .shamt(shamt), .rd(rd), .rs1(rs1),
    .rs2(rs2), .op(op), .dec_valid(dec_valid)
  );

  decode_checker #(.n_tests(n_tests), .reset_pc(reset_pc)) u_checker (
    .clk(clk), .reset(reset), .imem_rd(imem_rd), .imem_addr(imem_addr),
    .dec_valid(dec_valid), .pc(pc), .inst(inst), .imm_i(imm_i), .imm_u(imm_u),
    .imm_j(imm_j), .imm_b(imm_b), .imm_s(imm_s), .shamt(shamt), .rd(rd),
    .rs1(rs1), .rs2(rs2), .op(op), .tbl_name(tbl_name), .tbl_word(tbl_word),
    .tbl_rd(tbl_rd), .tbl_rs1(tbl_rs1), .tbl_rs2(tbl_rs2), .tbl_shamt(tbl_shamt),
    .tbl_op(tbl_op), .tbl_fmt(tbl_fmt), .tbl_imm(tbl_imm), .seen(seen),
    .pass_count(pass_count), .fail_count(fail_count), .other_errors(other_errors)
  );

  task automatic add_entry(input int i, input logic [95:0] name, input logic [31:0] word,
                           input logic [4:0] e_rd, input logic [4:0] e_rs1,
                           input logic [4:0] e_rs2, input logic [5:0] e_shamt,
                           input logic [19:0] e_op, input logic [7:0] fmt,
                           input logic [63:0] imm);
    tbl_name[i]  = name;
    tbl_word[i]  = word;
    tbl_rd[i]    = e_rd;
    tbl_rs1[i]   = e_rs1;
    tbl_rs2[i]   = e_rs2;
    tbl_shamt[i] = e_shamt;
    tbl_op[i]    = e_op;
    tbl_fmt[i]   = fmt;
    tbl_imm[i]   = imm;
  endtask

  // op is {rr, sh, uj, ebreak, ib}; fmt R has no immediate to check
  task automatic fill_table();
    add_entry(0, "addi_neg", 32'hFFF30293, 5, 6, 31, 63, 20'h00013, "I", -64'd1);
    add_entry(1, "addi_pos", 32'h12310093, 1, 2, 3, 35, 20'h00013, "I", 64'h123);
    add_entry(2, "lw_neg", 32'hFF85A503, 10, 11, 24, 56, 20'h0000D, "I", -64'd8);
    add_entry(3, "sd_pos", 32'h00713823, 16, 2, 7, 7, 20'h0002B, "S", 64'd16);
    add_entry(4, "sw_neg", 32'hFE942E23, 28, 8, 9, 41, 20'h00012, "S", -64'd4);
    add_entry(5, "beq_pos", 32'h00208463, 8, 1, 2, 2, 20'h00005, "B", 64'd8);
    add_entry(6, "bne_neg", 32'hFE4198E3, 17, 3, 4, 36, 20'h00006, "B", -64'd16);
    add_entry(7, "lui_pos", 32'h123452B7, 5, 8, 3, 35, 20'h00100, "U", 64'h12345000);
    add_entry(8, "auipc_neg", 32'hFFFFF317, 6, 31, 31, 63, 20'h00200, "U",
              64'hFFFFFFFFFFFFF000);
    add_entry(9, "jal_pos", 32'h001000EF, 1, 0, 1, 1, 20'h00300, "J", 64'h800);
    add_entry(10, "jal_neg", 32'hFFDFF06F, 0, 31, 29, 61, 20'h00300, "J", -64'd4);
    add_entry(11, "add", 32'h005201B3, 3, 4, 5, 5, 20'h04000, "R", 64'd0);
    add_entry(12, "sub", 32'h405201B3, 3, 4, 5, 5, 20'h05000, "R", 64'd0);
    add_entry(13, "mulw", 32'h029403BB, 7, 8, 9, 41, 20'h25000, "R", 64'd0);
    add_entry(14, "srai", 32'h4285D513, 10, 11, 8, 40, 20'h00C00, "I", 64'h428);
    add_entry(15, "slli", 32'h03F09093, 1, 1, 31, 63, 20'h00400, "I", 64'h3F);
    add_entry(16, "ebreak", 32'h00100073, 0, 0, 1, 1, 20'h00080, "I", 64'd1);
    add_entry(17, "ori_unlisted", 32'h00516093, 1, 2, 5, 5, 20'h00000, "I", 64'd5);
    add_entry(18, "andi_pos", 32'h7FF6F613, 12, 13, 31, 63, 20'h00018, "I", 64'h7FF);
    add_entry(19, "jalr", 32'h010100E7, 1, 2, 16, 16, 20'h00004, "I", 64'd16);
    add_entry(20, "lbu_neg", 32'hFFF14083, 1, 2, 31, 63, 20'h0000E, "I", -64'd1);
    add_entry(21, "sltiu", 32'h00713093, 1, 2, 7, 7, 20'h00015, "I", 64'd7);
    add_entry(22, "xori_neg", 32'hFFF14093, 1, 2, 31, 63, 20'h00016, "I", -64'd1);
    add_entry(23, "ld", 32'h00813083, 1, 2, 8, 8, 20'h0002A, "I", 64'd8);
    add_entry(24, "addiw", 32'h0011009B, 1, 2, 1, 1, 20'h0002F, "I", 64'd1);
    add_entry(25, "srli", 32'h00515093, 1, 2, 5, 5, 20'h00800, "I", 64'd5);
    add_entry(26, "sb", 32'h00310223, 4, 2, 3, 3, 20'h00010, "S", 64'd4);
    add_entry(27, "sh_neg", 32'hFE311F23, 30, 2, 3, 35, 20'h00011, "S", -64'd2);
    add_entry(28, "bge", 32'h00315663, 12, 2, 3, 3, 20'h00008, "B", 64'd12);
    add_entry(29, "bgeu_neg", 32'hFE317CE3, 25, 2, 3, 35, 20'h0000A, "B", -64'd8);
    add_entry(30, "sltu", 32'h003130B3, 1, 2, 3, 3, 20'h08000, "R", 64'd0);
    add_entry(31, "or", 32'h003160B3, 1, 2, 3, 3, 20'h12000, "R", 64'd0);
    add_entry(32, "and", 32'h003170B3, 1, 2, 3, 3, 20'h13000, "R", 64'd0);
    add_entry(33, "addw", 32'h003100BB, 1, 2, 3, 3, 20'h17000, "R", 64'd0);
    add_entry(34, "sllw", 32'h003110BB, 1, 2, 3, 3, 20'h19000, "R", 64'd0);
    add_entry(35, "divw", 32'h023140BB, 1, 2, 3, 35, 20'h26000, "R", 64'd0);
    add_entry(36, "remw", 32'h023160BB, 1, 2, 3, 35, 20'h28000, "R", 64'd0);
  endtask

  function automatic logic [31:0] fetch_word(input logic [xlen-1:0] addr);
    logic [xlen-1:0] idx;
    idx = (addr - reset_pc) >> 2;
    return (idx < n_tests) ? tbl_word[idx] : 32'h00000013;  // nop past the end
  endfunction

  // instruction memory, one cycle read
  always @(posedge clk) begin
    if (imem_rd) begin
      imem_data <= fetch_word(imem_addr);
    end
  end

  initial begin
    void'($urandom(32'h13093c9a));
    reset     = 1'b1;
    run       = 1'b0;
    hold      = 1'b0;
    imem_data = '0;
    fill_table();
    repeat (5) @(posedge clk);
    reset <= 1'b0;
    run   <= 1'b1;
    for (int i = 0; i < n_tests; i++) begin
      while (seen <= i) begin
        @(posedge clk);
        hold <= (($urandom & 3) != 0);  // mostly held so the queue fills
      end
    end
    $display("tests: %0d passed, %0d failed, %0d other errors",
             pass_count, fail_count, other_errors);
    if (fail_count == 0 && other_errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(limit_ns);
    $display("timeout: decoded results stopped arriving, %0d of %0d tests seen",
             seen, n_tests);
    $display("Done: errors found");
    $finish;
  end

endmodule

//--- sim/tb_clock.sv
// testbench clock source
`timescale 1ns/10ps

module tb_clock #(
  parameter real period = 4.0  // ns
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever #(period / 2.0) clk = ~clk;
  end

endmodule
